// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// Operation classes carried down the pipeline.
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		cls_alu_reg,
		cls_alu_imm,
		cls_lui,
		cls_load,
		cls_store,
		cls_branch,
		cls_jal,
		cls_halt,
		cls_bubble
	} op_class_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	// RV32E has sixteen registers.
	localparam int reg_addr_w = 4;
	localparam int reg_count  = 16;

	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_system = 7'b1110011;

	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	localparam logic [31:0] inst_ebreak = 32'h00100073;

endpackage

`default_nettype wire

// File: logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// Shared by the instruction and data buses.
	localparam int xlen = 32;

	localparam logic [xlen-1:0] reset_pc   = '0;
	localparam logic [xlen-1:0] inst_bytes = 4;

	// Word-only accesses.
	localparam logic [3:0] word_strobe = 4'b1111;

endpackage

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     redirect_valid,
	input  logic [bus_pkg::xlen-1:0] redirect_pc,
	input  logic                     halted,
	output logic                     imem_req,
	output logic [bus_pkg::xlen-1:0] imem_addr,
	input  logic                     imem_rvalid,
	input  logic [bus_pkg::xlen-1:0] imem_rdata,
	output logic                     fd_valid,
	output logic [bus_pkg::xlen-1:0] fd_pc,
	output logic [31:0]              fd_inst,
	input  logic                     fd_ready
);
	import bus_pkg::*;

	logic [xlen-1:0] pc;
	logic            pending;
	logic            discard;
	logic            in_flight;

	assign imem_addr = pc;

	// A request still out after this edge.
	assign in_flight = (pending | imem_req) & ~imem_rvalid;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc       <= reset_pc;
			pending  <= 1'b0;
			discard  <= 1'b0;
			imem_req <= 1'b0;
			fd_valid <= 1'b0;
		end else if (redirect_valid) begin
			pc       <= redirect_pc;
			fd_valid <= 1'b0;
			pending  <= in_flight;
			discard  <= in_flight;
			imem_req <= ~in_flight & ~halted;
		end else begin
			imem_req <= 1'b0;
			if (imem_req)
				pending <= 1'b1;
			if (fd_valid && fd_ready)
				fd_valid <= 1'b0;
			if (imem_rvalid) begin
				pending <= 1'b0;
				if (discard) begin
					discard <= 1'b0;
				end else begin
					fd_valid <= 1'b1;
					fd_pc    <= pc;
					fd_inst  <= imem_rdata;
					pc       <= pc + inst_bytes;
				end
			end
			// Next sequential fetch once the slot frees up.
			if (!halted && !pending && !imem_req && (!fd_valid || fd_ready))
				imem_req <= 1'b1;
		end
	end

	imem_response_pending: assert property (
		@(posedge clock) disable iff (reset) imem_rvalid |-> pending
	) else $error("imem_rvalid without a pending request");

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           fd_valid,
	input  logic [bus_pkg::xlen-1:0]       fd_pc,
	input  logic [31:0]                    fd_inst,
	output logic                           fd_ready,
	output logic [isa_pkg::reg_addr_w-1:0] rs1,
	output logic [isa_pkg::reg_addr_w-1:0] rs2,
	input  logic [bus_pkg::xlen-1:0]       rs1_val,
	input  logic [bus_pkg::xlen-1:0]       rs2_val,
	input  logic                           em_valid,
	input  logic [isa_pkg::reg_addr_w-1:0] em_rd,
	input  logic                           em_reg_we,
	input  logic                           redirect_valid,
	output logic                           de_valid,
	output logic [bus_pkg::xlen-1:0]       de_pc,
	output isa_pkg::op_class_t             de_class,
	output isa_pkg::alu_op_t               de_alu_op,
	output logic [isa_pkg::reg_addr_w-1:0] de_rd,
	output logic                           de_reg_we,
	output logic [bus_pkg::xlen-1:0]       de_src1,
	output logic [bus_pkg::xlen-1:0]       de_src2,
	output logic [bus_pkg::xlen-1:0]       de_imm,
	output logic                           de_branch_ne,
	input  logic                           de_ready
);
	import isa_pkg::*;
	import bus_pkg::*;

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [reg_addr_w-1:0] rd;
	op_class_t             op_class;
	alu_op_t               alu_op;
	logic [xlen-1:0]       imm;
	logic                  uses_rs1;
	logic                  uses_rs2;
	logic                  reg_we;
	logic                  hazard;
	logic                  halt_issued;

	assign opcode = fd_inst[6:0];
	assign funct3 = fd_inst[14:12];
	assign rd     = fd_inst[10:7];
	assign rs1    = fd_inst[18:15];
	assign rs2    = fd_inst[23:20];

	always_comb begin
		op_class = cls_bubble;
		alu_op   = alu_add;
		imm      = {{20{fd_inst[31]}}, fd_inst[31:20]};
		case (opcode)
			opc_op:     op_class = cls_alu_reg;
			opc_op_imm: op_class = cls_alu_imm;
			opc_load:   op_class = cls_load;
			opc_lui: begin
				op_class = cls_lui;
				imm      = {fd_inst[31:12], 12'b0};
			end
			opc_store: begin
				op_class = cls_store;
				imm      = {{20{fd_inst[31]}}, fd_inst[31:25], fd_inst[11:7]};
			end
			opc_branch: begin
				op_class = cls_branch;
				imm = {{19{fd_inst[31]}}, fd_inst[31], fd_inst[7], fd_inst[30:25],
					fd_inst[11:8], 1'b0};
			end
			opc_jal: begin
				op_class = cls_jal;
				imm = {{11{fd_inst[31]}}, fd_inst[31], fd_inst[19:12], fd_inst[20],
					fd_inst[30:21], 1'b0};
			end
			opc_system: begin
				if (fd_inst == inst_ebreak)
					op_class = cls_halt;
			end
			default: op_class = cls_bubble;
		endcase
		if (op_class == cls_alu_reg || op_class == cls_alu_imm) begin
			case (funct3)
				f3_add: begin
					if (op_class == cls_alu_reg && fd_inst[30])
						alu_op = alu_sub;
				end
				f3_slt: alu_op = alu_slt;
				f3_xor: alu_op = alu_xor;
				f3_or:  alu_op = alu_or;
				f3_and: alu_op = alu_and;
				default: alu_op = alu_add;
			endcase
		end
	end

	assign uses_rs1 = op_class inside {cls_alu_reg, cls_alu_imm, cls_load, cls_store,
		cls_branch};
	assign uses_rs2 = op_class inside {cls_alu_reg, cls_store, cls_branch};
	// Writes to x0 are dropped here, so x0 never causes a stall.
	assign reg_we = (op_class inside {cls_alu_reg, cls_alu_imm, cls_lui, cls_load, cls_jal})
		&& rd != '0;

	// No bypassing, so wait until producers have left decode and execute.
	assign hazard =
		(uses_rs1 && ((de_valid && de_reg_we && de_rd == rs1) ||
			(em_valid && em_reg_we && em_rd == rs1))) ||
		(uses_rs2 && ((de_valid && de_reg_we && de_rd == rs2) ||
			(em_valid && em_reg_we && em_rd == rs2)));

	assign fd_ready = (!de_valid || de_ready) && !hazard && !halt_issued;

	always_ff @(posedge clock) begin
		if (reset) begin
			de_valid    <= 1'b0;
			halt_issued <= 1'b0;
		end else if (redirect_valid) begin
			de_valid <= 1'b0;
		end else begin
			if (de_valid && de_ready)
				de_valid <= 1'b0;
			if (fd_valid && fd_ready) begin
				de_valid     <= 1'b1;
				de_pc        <= fd_pc;
				de_class     <= op_class;
				de_alu_op    <= alu_op;
				de_rd        <= rd;
				de_reg_we    <= reg_we;
				de_src1      <= rs1_val;
				de_src2      <= rs2_val;
				de_imm       <= imm;
				de_branch_ne <= funct3[0];
				if (op_class == cls_halt)
					halt_issued <= 1'b1;
			end
		end
	end

	no_issue_after_ebreak: assert property (
		@(posedge clock) disable iff (reset) halt_issued |=> !$rose(de_valid)
	) else $error("decode issued after EBREAK");

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [isa_pkg::reg_addr_w-1:0] rs1,
	input  logic [isa_pkg::reg_addr_w-1:0] rs2,
	output logic [bus_pkg::xlen-1:0]       rs1_val,
	output logic [bus_pkg::xlen-1:0]       rs2_val,
	input  logic                           wb_we,
	input  logic [isa_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [bus_pkg::xlen-1:0]       wb_data
);
	import isa_pkg::*;
	import bus_pkg::*;

	logic [xlen-1:0] regs [reg_count];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wb_we && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// Same-cycle writes show through to the reads.
	assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           de_valid,
	input  logic [bus_pkg::xlen-1:0]       de_pc,
	input  isa_pkg::op_class_t             de_class,
	input  isa_pkg::alu_op_t               de_alu_op,
	input  logic [isa_pkg::reg_addr_w-1:0] de_rd,
	input  logic                           de_reg_we,
	input  logic [bus_pkg::xlen-1:0]       de_src1,
	input  logic [bus_pkg::xlen-1:0]       de_src2,
	input  logic [bus_pkg::xlen-1:0]       de_imm,
	input  logic                           de_branch_ne,
	output logic                           de_ready,
	output logic                           em_valid,
	output logic [bus_pkg::xlen-1:0]       em_pc,
	output isa_pkg::op_class_t             em_class,
	output logic [isa_pkg::reg_addr_w-1:0] em_rd,
	output logic                           em_reg_we,
	output logic [bus_pkg::xlen-1:0]       em_result,
	output logic [bus_pkg::xlen-1:0]       em_store_data,
	input  logic                           em_ready,
	output logic                           redirect_valid,
	output logic [bus_pkg::xlen-1:0]       redirect_pc
);
	import isa_pkg::*;
	import bus_pkg::*;

	logic [xlen-1:0] operand_b;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] result;
	logic            taken;

	assign operand_b = (de_class == cls_alu_reg || de_class == cls_branch) ? de_src2 : de_imm;

	always_comb begin
		case (de_alu_op)
			alu_sub: alu_out = de_src1 - operand_b;
			alu_and: alu_out = de_src1 & operand_b;
			alu_or:  alu_out = de_src1 | operand_b;
			alu_xor: alu_out = de_src1 ^ operand_b;
			alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(de_src1) < $signed(operand_b)};
			default: alu_out = de_src1 + operand_b;
		endcase
	end

	always_comb begin
		case (de_class)
			cls_lui:             result = de_imm;
			cls_jal:             result = de_pc + inst_bytes;
			cls_load, cls_store: result = de_src1 + de_imm;
			default:             result = alu_out;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Branch resolution. Fetch runs not-taken, so only taken flows redirect.
	//////////////////////////////////////////////////////////////////////
	assign taken = (de_class == cls_jal) ||
		(de_class == cls_branch && ((de_src1 == de_src2) != de_branch_ne));

	assign de_ready       = !em_valid || em_ready;
	assign redirect_valid = de_valid && de_ready && taken;
	assign redirect_pc    = de_pc + de_imm;

	always_ff @(posedge clock) begin
		if (reset) begin
			em_valid <= 1'b0;
		end else begin
			if (em_valid && em_ready)
				em_valid <= 1'b0;
			if (de_valid && de_ready) begin
				em_valid      <= 1'b1;
				em_pc         <= de_pc;
				em_class      <= de_class;
				em_rd         <= de_rd;
				em_reg_we     <= de_reg_we;
				em_result     <= result;
				em_store_data <= de_src2;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/memory_unit.sv
`timescale 1ns/1ns
`default_nettype none

module memory_unit (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           em_valid,
	input  logic [bus_pkg::xlen-1:0]       em_pc,
	input  isa_pkg::op_class_t             em_class,
	input  logic [isa_pkg::reg_addr_w-1:0] em_rd,
	input  logic                           em_reg_we,
	input  logic [bus_pkg::xlen-1:0]       em_result,
	input  logic [bus_pkg::xlen-1:0]       em_store_data,
	output logic                           em_ready,
	output logic                           dmem_req,
	output logic                           dmem_we,
	output logic [bus_pkg::xlen-1:0]       dmem_addr,
	output logic [bus_pkg::xlen-1:0]       dmem_wdata,
	output logic [3:0]                     dmem_wstrb,
	input  logic                           dmem_rvalid,
	input  logic [bus_pkg::xlen-1:0]       dmem_rdata,
	output logic                           wb_we,
	output logic [isa_pkg::reg_addr_w-1:0] wb_rd,
	output logic [bus_pkg::xlen-1:0]       wb_data,
	output logic                           retire_valid,
	output logic [bus_pkg::xlen-1:0]       retire_pc,
	output logic                           retire_we,
	output logic [isa_pkg::reg_addr_w-1:0] retire_rd,
	output logic [bus_pkg::xlen-1:0]       retire_data,
	output logic                           halted
);
	import isa_pkg::*;
	import bus_pkg::*;

	logic mem_op;
	logic started;
	logic pending;

	// A load stays on the em link until its data is back, which keeps it
	// visible to the decode interlock.
	assign mem_op   = em_valid && (em_class == cls_load || em_class == cls_store);
	assign em_ready = !mem_op || dmem_rvalid;

	assign dmem_wstrb = word_strobe;

	assign wb_we   = retire_valid && retire_we;
	assign wb_rd   = retire_rd;
	assign wb_data = retire_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			dmem_req     <= 1'b0;
			started      <= 1'b0;
			pending      <= 1'b0;
			retire_valid <= 1'b0;
			halted       <= 1'b0;
		end else begin
			dmem_req     <= 1'b0;
			retire_valid <= 1'b0;
			if (mem_op && !started) begin
				dmem_req   <= 1'b1;
				dmem_we    <= (em_class == cls_store);
				dmem_addr  <= em_result;
				dmem_wdata <= em_store_data;
				started    <= 1'b1;
				pending    <= 1'b1;
			end
			if (dmem_rvalid)
				pending <= 1'b0;
			if (em_valid && em_ready) begin
				started      <= 1'b0;
				retire_valid <= 1'b1;
				retire_pc    <= em_pc;
				retire_we    <= em_reg_we;
				retire_rd    <= em_rd;
				retire_data  <= (em_class == cls_load) ? dmem_rdata : em_result;
				if (em_class == cls_halt)
					halted <= 1'b1;
			end
		end
	end

	dmem_response_pending: assert property (
		@(posedge clock) disable iff (reset) dmem_rvalid |-> pending
	) else $error("dmem_rvalid without a pending access");

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
	input  logic                           clock,
	input  logic                           reset,
	output logic                           imem_req,
	output logic [bus_pkg::xlen-1:0]       imem_addr,
	input  logic                           imem_rvalid,
	input  logic [bus_pkg::xlen-1:0]       imem_rdata,
	output logic                           dmem_req,
	output logic                           dmem_we,
	output logic [bus_pkg::xlen-1:0]       dmem_addr,
	output logic [bus_pkg::xlen-1:0]       dmem_wdata,
	output logic [3:0]                     dmem_wstrb,
	input  logic                           dmem_rvalid,
	input  logic [bus_pkg::xlen-1:0]       dmem_rdata,
	output logic                           retire_valid,
	output logic [bus_pkg::xlen-1:0]       retire_pc,
	output logic                           retire_we,
	output logic [isa_pkg::reg_addr_w-1:0] retire_rd,
	output logic [bus_pkg::xlen-1:0]       retire_data,
	output logic                           halted
);
	import isa_pkg::*;
	import bus_pkg::*;

	logic                  redirect_valid;
	logic [xlen-1:0]       redirect_pc;
	logic                  fd_valid, fd_ready;
	logic [xlen-1:0]       fd_pc;
	logic [31:0]           fd_inst;
	logic [reg_addr_w-1:0] rs1, rs2;
	logic [xlen-1:0]       rs1_val, rs2_val;
	logic                  de_valid, de_ready, de_reg_we, de_branch_ne;
	logic [xlen-1:0]       de_pc, de_src1, de_src2, de_imm;
	op_class_t             de_class;
	alu_op_t               de_alu_op;
	logic [reg_addr_w-1:0] de_rd;
	logic                  em_valid, em_ready, em_reg_we;
	logic [xlen-1:0]       em_pc, em_result, em_store_data;
	op_class_t             em_class;
	logic [reg_addr_w-1:0] em_rd;
	logic                  wb_we;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0]       wb_data;

	fetch_unit fetch_unit_inst (.*);

	decode_unit decode_unit_inst (.*);

	register_file register_file_inst (.*);

	execute_unit execute_unit_inst (.*);

	memory_unit memory_unit_inst (.*);

endmodule

`default_nettype wire

// File: verification/cpu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;
	import bus_pkg::*;

	typedef struct packed {
		logic [31:0] pc;
		logic        we;
		logic [3:0]  rd;
		logic [31:0] data;
	} retire_entry_t;

	localparam logic [31:0] rng_seed = 35554;
	localparam int prog_len   = 18;
	localparam int n_expected = 16;
	localparam int timeout_cycles = n_expected * 40;
	localparam int data_words = 64;

	localparam logic [31:0] program_words [prog_len] = '{
		32'h00500093, // addi x1, x0, 5
		32'h00708113, // addi x2, x1, 7
		32'h123451b7, // lui  x3, 0x12345
		32'h00208233, // add  x4, x1, x2
		32'h401102b3, // sub  x5, x2, x1
		32'h00524333, // xor  x6, x4, x5
		32'h0020e3b3, // or   x7, x1, x2
		32'h0042a433, // slt  x8, x5, x4
		32'h007174b3, // and  x9, x2, x7
		32'h04402023, // sw   x4, 64(x0)
		32'h04002503, // lw   x10, 64(x0)
		32'h00108463, // beq  x1, x1, +8
		32'h06300593, // addi x11, x0, 99 (skipped)
		32'h0080066f, // jal  x12, +8
		32'h04d00693, // addi x13, x0, 77 (skipped)
		32'h00109463, // bne  x1, x1, +8 (not taken)
		32'h00150713, // addi x14, x10, 1
		32'h00100073  // ebreak
	};

	// Columns are pc, we, rd, data. rd and data only matter when we is set.
	localparam retire_entry_t expected [n_expected] = '{
		'{32'h00, 1'b1, 4'd1,  32'h00000005},
		'{32'h04, 1'b1, 4'd2,  32'h0000000c},
		'{32'h08, 1'b1, 4'd3,  32'h12345000},
		'{32'h0c, 1'b1, 4'd4,  32'h00000011},
		'{32'h10, 1'b1, 4'd5,  32'h00000007},
		'{32'h14, 1'b1, 4'd6,  32'h00000016},
		'{32'h18, 1'b1, 4'd7,  32'h0000000d},
		'{32'h1c, 1'b1, 4'd8,  32'h00000001},
		'{32'h20, 1'b1, 4'd9,  32'h0000000c},
		'{32'h24, 1'b0, 4'd0,  32'h00000000},
		'{32'h28, 1'b1, 4'd10, 32'h00000011},
		'{32'h2c, 1'b0, 4'd0,  32'h00000000},
		'{32'h34, 1'b1, 4'd12, 32'h00000038},
		'{32'h3c, 1'b0, 4'd0,  32'h00000000},
		'{32'h40, 1'b1, 4'd14, 32'h00000012},
		'{32'h44, 1'b0, 4'd0,  32'h00000000}
	};

	logic            clock;
	logic            reset;
	logic            imem_req;
	logic [xlen-1:0] imem_addr;
	logic            imem_rvalid;
	logic [xlen-1:0] imem_rdata;
	logic            dmem_req;
	logic            dmem_we;
	logic [xlen-1:0] dmem_addr;
	logic [xlen-1:0] dmem_wdata;
	logic [3:0]      dmem_wstrb;
	logic            dmem_rvalid;
	logic [xlen-1:0] dmem_rdata;
	logic            retire_valid;
	logic [xlen-1:0] retire_pc;
	logic            retire_we;
	logic [3:0]      retire_rd;
	logic [xlen-1:0] retire_data;
	logic            halted;

	logic [31:0] data_mem [data_words];
	logic [31:0] imem_rng;
	logic [31:0] dmem_rng;
	logic [31:0] imem_addr_q;
	logic [31:0] dmem_addr_q;
	logic        imem_busy;
	logic        dmem_busy;
	logic        imem_fire;
	logic        dmem_fire;
	int          imem_wait;
	int          dmem_wait;
	int          cycle_count = 0;

	cpu_core cpu_core_inst (.*);

	always #2 clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Past the program the model returns the address itself.
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if (addr[31:2] < prog_len)
			return program_words[addr[31:2]];
		return addr;
	endfunction

	function automatic string mismatch_text(input string name, input logic [31:0] got,
		input logic [31:0] want);
		return $sformatf("FAILED %s: got %h, expected %h", name, got, want);
	endfunction

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
	endtask

	task automatic wait_for_retire();
		do
			@(posedge clock);
		while (retire_valid !== 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory models with random latency.
	//////////////////////////////////////////////////////////////////////
	always @(posedge clock) begin
		imem_fire = 1'b0;
		if (reset) begin
			imem_busy = 1'b0;
		end else begin
			if (imem_busy) begin
				if (imem_wait == 1) begin
					imem_fire = 1'b1;
					imem_busy = 1'b0;
				end else begin
					imem_wait = imem_wait - 1;
				end
			end
			if (imem_req) begin
				assert (!imem_busy) else begin
					report_failure("Instruction request issued while another was outstanding");
					$fatal(1);
				end
				imem_rng    = xorshift32(imem_rng);
				imem_wait   = imem_rng[1:0] + 1;
				imem_busy   = 1'b1;
				imem_addr_q = imem_addr;
			end
		end
		#1;
		imem_rvalid = imem_fire;
		imem_rdata  = fetch_word(imem_addr_q);
	end

	always @(posedge clock) begin
		dmem_fire = 1'b0;
		if (reset) begin
			dmem_busy = 1'b0;
		end else begin
			if (dmem_busy) begin
				if (dmem_wait == 1) begin
					dmem_fire = 1'b1;
					dmem_busy = 1'b0;
				end else begin
					dmem_wait = dmem_wait - 1;
				end
			end
			if (dmem_req) begin
				assert (!dmem_busy) else begin
					report_failure("Data request issued while another was outstanding");
					$fatal(1);
				end
				assert (dmem_addr < data_words * 4) else begin
					report_failure("Data access outside the modeled memory");
					$fatal(1);
				end
				if (dmem_we) begin
					assert (dmem_wstrb === 4'b1111) else begin
						report_failure(mismatch_text("dmem_wstrb", dmem_wstrb, 4'b1111));
						$fatal(1);
					end
					data_mem[dmem_addr[7:2]] = dmem_wdata;
				end
				dmem_rng    = xorshift32(dmem_rng);
				dmem_wait   = dmem_rng[1:0] + 1;
				dmem_busy   = 1'b1;
				dmem_addr_q = dmem_addr;
			end
		end
		#1;
		dmem_rvalid = dmem_fire;
		dmem_rdata  = data_mem[dmem_addr_q[7:2]];
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		assert (cycle_count < timeout_cycles) else begin
			report_failure($sformatf("Timed out after %0d cycles", cycle_count));
			$fatal(1);
		end
	end

	initial begin
		clock       = 1'b0;
		reset       = 1'b1;
		imem_rvalid = 1'b0;
		imem_rdata  = '0;
		dmem_rvalid = 1'b0;
		dmem_rdata  = '0;
		imem_addr_q = '0;
		dmem_addr_q = '0;
		imem_rng    = rng_seed;
		dmem_rng    = xorshift32(rng_seed);
		for (int i = 0; i < data_words; i++)
			data_mem[i] = 32'h5a5a0000 ^ (i << 2);

		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		@(posedge clock);
		assert (halted === 1'b0 && retire_valid === 1'b0) else begin
			report_failure("halted or retire_valid was high right after reset");
			$fatal(1);
		end

		// Retires arrive in program order.
		for (int i = 0; i < n_expected; i++) begin
			wait_for_retire();
			assert (retire_pc === expected[i].pc) else begin
				report_failure(mismatch_text("retire_pc", retire_pc, expected[i].pc));
				$fatal(1);
			end
			assert (retire_we === expected[i].we) else begin
				report_failure(mismatch_text("retire_we", retire_we, expected[i].we));
				$fatal(1);
			end
			if (expected[i].we) begin
				assert (retire_rd === expected[i].rd) else begin
					report_failure(mismatch_text("retire_rd", retire_rd, expected[i].rd));
					$fatal(1);
				end
				assert (retire_data === expected[i].data) else begin
					report_failure(mismatch_text("retire_data", retire_data, expected[i].data));
					$fatal(1);
				end
			end
			assert (halted === (i == n_expected - 1)) else begin
				report_failure(mismatch_text("halted", halted, i == n_expected - 1));
				$fatal(1);
			end
		end

		repeat (50) begin
			@(posedge clock);
			assert (retire_valid === 1'b0 && halted === 1'b1) else begin
				report_failure("An instruction retired after EBREAK or halted dropped");
				$fatal(1);
			end
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/register_file.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/cpu_core.sv
verification/cpu_core_tb.sv
